// File: common/scope_pkg.sv
package scope_pkg;

   // register bus
   localparam int BYTECNT_SIZE = 7;

   // adc sample width
   localparam int SAMPLE_W = 12;

   // register map
   localparam logic [7:0] ADDR_GAIN       = 8'd0;
   localparam logic [7:0] ADDR_SETTINGS   = 8'd1;
   localparam logic [7:0] ADDR_STATUS     = 8'd2;
   localparam logic [7:0] ADDR_TRIG_LEVEL = 8'd3;

   // one host register access
   typedef struct packed {
      logic [7:0]              address;
      logic [BYTECNT_SIZE-1:0] bytecnt;  // byte lane within the register
      logic [7:0]              wdata;
      logic                    read;
      logic                    write;    // one-cycle strobe
   } reg_req_t;

   typedef struct packed {
      logic [7:0] gain;        // pwm increment
      logic       source_adc;  // 1 adc, 0 counter
   } front_cfg_t;

   typedef struct packed {
      logic                active;
      logic [SAMPLE_W-1:0] level;  // msb picks polarity
   } trig_cfg_t;

   // what the two panel LEDs show
   typedef enum logic [1:0] {
      LED_STATE     = 2'b00,
      LED_HEARTBEAT = 2'b01,
      LED_FLASH     = 2'b10,
      LED_OFF       = 2'b11
   } led_sel_t;

endpackage

// File: verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  scope_pkg::reg_req_t   reg_req_i,
   input  logic                  armed_i,
   input  logic                  triggered_i,
   output logic [7:0]            reg_rdata_o,
   output scope_pkg::front_cfg_t front_cfg_o,
   output scope_pkg::trig_cfg_t  trig_cfg_o,
   output logic                  arm_o,
   output scope_pkg::led_sel_t   led_sel_o
);
   import scope_pkg::*;

   logic [7:0]          gain_q;
   logic                source_adc_q;
   led_sel_t            led_sel_q;
   logic                trig_active_q;
   logic [SAMPLE_W-1:0] trig_level_q;
   logic                arm_q;
   logic                wr_byte0;
   logic                wr_byte1;

   assign wr_byte0 = reg_req_i.write && (reg_req_i.bytecnt == '0);
   assign wr_byte1 = reg_req_i.write && (reg_req_i.bytecnt == BYTECNT_SIZE'(1));

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_q        <= '0;
         source_adc_q  <= 1'b0;
         led_sel_q     <= LED_STATE;
         trig_active_q <= 1'b0;
         trig_level_q  <= '0;
         arm_q         <= 1'b0;
      end else begin
         arm_q <= 1'b0;  // only high for the cycle after the write
         if (wr_byte0 && reg_req_i.address == ADDR_GAIN)
            gain_q <= reg_req_i.wdata;
         if (wr_byte0 && reg_req_i.address == ADDR_SETTINGS) begin
            source_adc_q  <= reg_req_i.wdata[0];
            led_sel_q     <= led_sel_t'(reg_req_i.wdata[2:1]);
            arm_q         <= reg_req_i.wdata[3];
            trig_active_q <= reg_req_i.wdata[4];
         end
         if (wr_byte0 && reg_req_i.address == ADDR_TRIG_LEVEL)
            trig_level_q[7:0] <= reg_req_i.wdata;
         if (wr_byte1 && reg_req_i.address == ADDR_TRIG_LEVEL)
            trig_level_q[SAMPLE_W-1:8] <= reg_req_i.wdata[SAMPLE_W-9:0];
      end
   end

   // read mux, combinational and zero when idle
   always_comb begin
      reg_rdata_o = 8'h00;
      if (reg_req_i.read) begin
         case (reg_req_i.address)
            ADDR_GAIN:
               if (reg_req_i.bytecnt == '0)
                  reg_rdata_o = gain_q;
            ADDR_SETTINGS:
               if (reg_req_i.bytecnt == '0)
                  reg_rdata_o = {3'b000, trig_active_q, 1'b0, led_sel_q, source_adc_q};
            ADDR_STATUS:
               if (reg_req_i.bytecnt == '0)
                  reg_rdata_o = {6'b000000, triggered_i, armed_i};
            ADDR_TRIG_LEVEL:
               if (reg_req_i.bytecnt == '0)
                  reg_rdata_o = trig_level_q[7:0];
               else if (reg_req_i.bytecnt == BYTECNT_SIZE'(1))
                  reg_rdata_o = {{(16 - SAMPLE_W){1'b0}}, trig_level_q[SAMPLE_W-1:8]};
            default:
               reg_rdata_o = 8'h00;
         endcase
      end
   end

   assign front_cfg_o.gain       = gain_q;
   assign front_cfg_o.source_adc = source_adc_q;
   assign trig_cfg_o.active      = trig_active_q;
   assign trig_cfg_o.level       = trig_level_q;
   assign arm_o                  = arm_q;
   assign led_sel_o              = led_sel_q;

endmodule

// File: verilog/panel_leds.sv
`timescale 1ns/1ns

module panel_leds #(
   parameter int TIMER_W = 26
) (
   input  logic                clk_usb,
   input  logic                reset,
   input  scope_pkg::led_sel_t led_sel_i,
   input  logic                armed_i,
   input  logic                triggered_i,
   output logic                freq_measure_o,
   output logic                flash_pattern_o,
   output logic                led_armed_o,
   output logic                led_capture_o
);
   import scope_pkg::*;

   logic [TIMER_W-1:0] timer_q;
   logic               meas_bit_q;  // delayed copy for edge detect
   logic               flash_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer_q        <= '0;
         meas_bit_q     <= 1'b0;
         freq_measure_o <= 1'b0;
         flash_q        <= 1'b0;
      end else begin
         timer_q        <= timer_q + 1'b1;
         meas_bit_q     <= timer_q[TIMER_W-4];
         freq_measure_o <= timer_q[TIMER_W-4] && !meas_bit_q;  // rising edge only
         if (timer_q[TIMER_W-1])
            flash_q <= ~timer_q[TIMER_W-3];
      end
   end

   assign flash_pattern_o = flash_q;

   always_comb begin
      case (led_sel_i)
         LED_STATE: begin
            led_armed_o   = armed_i;
            led_capture_o = triggered_i;
         end
         LED_HEARTBEAT: begin
            led_armed_o   = timer_q[TIMER_W-2];
            led_capture_o = timer_q[TIMER_W-2];
         end
         LED_FLASH: begin
            led_armed_o   = flash_q;
            led_capture_o = flash_q;
         end
         default: begin  // off
            led_armed_o   = 1'b0;
            led_capture_o = 1'b0;
         end
      endcase
   end

endmodule

// File: trigger/adc_front_end.sv
`timescale 1ns/1ns

module adc_front_end (
   input  logic                            clk_usb,
   input  logic                            reset,
   input  scope_pkg::front_cfg_t           front_cfg_i,
   input  logic [scope_pkg::SAMPLE_W-1:0]  adc_data_i,
   output logic [scope_pkg::SAMPLE_W-1:0]  sample_o,
   output logic                            amp_gain_o
);
   import scope_pkg::*;

   logic [SAMPLE_W-1:0] count_q;  // test pattern source
   logic [SAMPLE_W-1:0] stage1_q;
   logic [SAMPLE_W-1:0] stage2_q;
   logic [8:0]          pwm_acc_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count_q   <= '0;
         pwm_acc_q <= '0;
      end else begin
         count_q   <= count_q + 1'b1;
         // carry out of bit 8 is dropped each cycle and drives the pwm
         pwm_acc_q <= {1'b0, pwm_acc_q[7:0]} + {1'b0, front_cfg_i.gain};
      end
   end

   // two stages so the sample lines up with the capture path delay
   always_ff @(posedge clk_usb) begin
      stage1_q <= front_cfg_i.source_adc ? adc_data_i : count_q;
      stage2_q <= stage1_q;
   end

   assign sample_o   = stage2_q;
   assign amp_gain_o = pwm_acc_q[8];

endmodule

// File: trigger/level_trigger.sv
`timescale 1ns/1ns

module level_trigger (
   input  logic                            clk_usb,
   input  logic                            reset,
   input  scope_pkg::trig_cfg_t            trig_cfg_i,
   input  logic                            arm_i,
   input  logic [scope_pkg::SAMPLE_W-1:0]  sample_i,
   output logic                            trigger_adc_o,
   output logic                            armed_o,
   output logic                            triggered_o
);
   import scope_pkg::*;

   logic armed_q;
   logic triggered_q;
   logic level_hit;

   // level msb set means trigger on high, clear means trigger on low
   assign level_hit = trig_cfg_i.level[SAMPLE_W-1] ? (sample_i > trig_cfg_i.level)
                                                   : (sample_i < trig_cfg_i.level);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         armed_q       <= 1'b0;
         triggered_q   <= 1'b0;
         trigger_adc_o <= 1'b0;
      end else begin
         // no refire while the first pulse is still out
         trigger_adc_o <= armed_q && trig_cfg_i.active && !trigger_adc_o && level_hit;

         if (arm_i) begin  // rearm wins over a pulse in flight
            armed_q     <= 1'b1;
            triggered_q <= 1'b0;
         end else if (trigger_adc_o) begin
            armed_q     <= 1'b0;
            triggered_q <= 1'b1;
         end
      end
   end

   assign armed_o     = armed_q;
   assign triggered_o = triggered_q;

endmodule

// File: verilog/scope_top.sv
`timescale 1ns/1ns

module scope_top #(
   parameter int TIMER_W = 26
) (
   input  logic                            clk_usb,
   input  logic                            reset,
   input  scope_pkg::reg_req_t             reg_req_i,
   input  logic [scope_pkg::SAMPLE_W-1:0]  adc_data_i,
   output logic [7:0]                      reg_rdata_o,
   output logic [scope_pkg::SAMPLE_W-1:0]  sample_o,
   output logic                            trigger_adc_o,
   output logic                            amp_gain_o,
   output logic                            freq_measure_o,
   output logic                            flash_pattern_o,
   output logic                            led_armed_o,
   output logic                            led_capture_o
);
   import scope_pkg::*;

   front_cfg_t front_cfg;
   trig_cfg_t  trig_cfg;
   led_sel_t   led_sel;
   logic       arm;
   logic       armed;
   logic       triggered;

   reg_file u_reg_file (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .reg_req_i   (reg_req_i),
      .armed_i     (armed),
      .triggered_i (triggered),
      .reg_rdata_o (reg_rdata_o),
      .front_cfg_o (front_cfg),
      .trig_cfg_o  (trig_cfg),
      .arm_o       (arm),
      .led_sel_o   (led_sel)
   );

   adc_front_end u_adc_front_end (
      .clk_usb     (clk_usb),
      .reset       (reset),
      .front_cfg_i (front_cfg),
      .adc_data_i  (adc_data_i),
      .sample_o    (sample_o),
      .amp_gain_o  (amp_gain_o)
   );

   // fires off the same pipelined sample that goes out on sample_o
   level_trigger u_level_trigger (
      .clk_usb       (clk_usb),
      .reset         (reset),
      .trig_cfg_i    (trig_cfg),
      .arm_i         (arm),
      .sample_i      (sample_o),
      .trigger_adc_o (trigger_adc_o),
      .armed_o       (armed),
      .triggered_o   (triggered)
   );

   panel_leds #(
      .TIMER_W (TIMER_W)
   ) u_panel_leds (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .led_sel_i       (led_sel),
      .armed_i         (armed),
      .triggered_i     (triggered),
      .freq_measure_o  (freq_measure_o),
      .flash_pattern_o (flash_pattern_o),
      .led_armed_o     (led_armed_o),
      .led_capture_o   (led_capture_o)
   );

endmodule

// File: tb/scope_asserts.sv
`timescale 1ns/1ns

module scope_asserts (
   input logic clk_usb,
   input logic reset,
   input logic trigger_i,
   input logic arm_i,
   input logic armed_i,
   input logic triggered_i
);

   int fail_count = 0;  // polled by the testbench after each step

   // one pulse, then the state falls to triggered unless a rearm lands on it
   pulse_one_cycle: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_i && !arm_i |=> !trigger_i && !armed_i && triggered_i)
      else begin
         fail_count++;
         $error("trigger pulse longer than one cycle");
      end

   // armed only drops the cycle after the pulse
   no_fire_unarmed: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_i |-> armed_i)
      else begin
         fail_count++;
         $error("trigger fired while not armed");
      end

   state_exclusive: assert property (@(posedge clk_usb) disable iff (reset)
      !(armed_i && triggered_i))
      else begin
         fail_count++;
         $error("armed and triggered both high");
      end

endmodule

bind level_trigger scope_asserts u_scope_asserts (
   .clk_usb     (clk_usb),
   .reset       (reset),
   .trigger_i   (trigger_adc_o),
   .arm_i       (arm_i),
   .armed_i     (armed_o),
   .triggered_i (triggered_o)
);

// File: tb/scope_tb.sv
`timescale 1ns/1ns

module scope_tb;
   import scope_pkg::*;

   localparam int TIMER_W = 8;

   logic                clk_usb;
   logic                reset;
   reg_req_t            reg_req;
   logic [SAMPLE_W-1:0] adc_data;
   logic [7:0]          reg_rdata;
   logic [SAMPLE_W-1:0] sample;
   logic                trigger_adc;
   logic                amp_gain;
   logic                freq_measure;
   logic                flash_pattern;
   logic                led_armed;
   logic                led_capture;

   // one entry per pattern line
   string       step_name[$];
   logic [31:0] step_op[$];
   logic [31:0] step_addr[$];
   logic [31:0] step_cnt[$];
   logic [31:0] step_data[$];
   logic [31:0] step_exp[$];

   integer              seed = 32'hfb64;
   int                  errors = 0;
   int                  limit_cycles = 0;
   int                  cycle_count;       // edges since reset went low
   logic [SAMPLE_W-1:0] idle_sample = '0;  // adc value between test samples

   scope_top #(
      .TIMER_W (TIMER_W)
   ) dut0 (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .reg_req_i       (reg_req),
      .adc_data_i      (adc_data),
      .reg_rdata_o     (reg_rdata),
      .sample_o        (sample),
      .trigger_adc_o   (trigger_adc),
      .amp_gain_o      (amp_gain),
      .freq_measure_o  (freq_measure),
      .flash_pattern_o (flash_pattern),
      .led_armed_o     (led_armed),
      .led_capture_o   (led_capture)
   );

   initial begin
      clk_usb = 1'b0;
      forever #4 clk_usb = ~clk_usb;
   end

   // timer and sample counter both count from the first edge out of reset
   always @(posedge clk_usb) begin
      if (reset)
         cycle_count <= 0;
      else
         cycle_count <= cycle_count + 1;
   end

   task automatic stop_on_error(input string msg);
      errors++;
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp,
                             input logic [7:0] act);
      if (act !== exp)
         stop_on_error($sformatf("Error %s expected 0x%02h actual 0x%02h", name, exp, act));
   endtask

   task automatic check_sample(input string name, input logic [SAMPLE_W-1:0] exp,
                               input logic [SAMPLE_W-1:0] act);
      if (act !== exp)
         stop_on_error($sformatf("Error %s expected 0x%03h actual 0x%03h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         stop_on_error($sformatf("Error %s expected %b actual %b", name, exp, act));
   endtask

   // flash value after edge k, worked out from the timer value k-1
   function automatic logic flash_at(input int k);
      logic [TIMER_W-1:0] t;
      if (k == 0)
         return 1'b0;
      t = TIMER_W'(k - 1);
      return t[TIMER_W-1] && !t[TIMER_W-3];  // lower half holds the 0 left at wrap
   endfunction

   // inputs change 1 ns after the edge
   task automatic next_cycle();
      @(posedge clk_usb);
      #1;
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [BYTECNT_SIZE-1:0] cnt,
                            input logic [7:0] data);
      reg_req.address = addr;
      reg_req.bytecnt = cnt;
      reg_req.wdata   = data;
      reg_req.write   = 1'b1;
      next_cycle();
      reg_req = '0;
   endtask

   task automatic bus_read_check(input string name, input logic [7:0] addr,
                                 input logic [BYTECNT_SIZE-1:0] cnt, input logic [7:0] exp);
      reg_req.address = addr;
      reg_req.bytecnt = cnt;
      reg_req.read    = 1'b1;
      #2;  // read data is combinational
      check_byte(name, exp, reg_rdata);
      next_cycle();
      reg_req = '0;
   endtask

   task automatic drive_adc_samples(input string name, input int n);
      logic [SAMPLE_W-1:0] sent[$];
      logic [31:0]         r;
      for (int i = 0; i < n + 2; i++) begin
         if (i >= 2)
            check_sample(name, sent[i-2], sample);  // two stage delay
         if (i < n) begin
            r = $random(seed);
            sent.push_back(r[SAMPLE_W-1:0]);
            adc_data = r[SAMPLE_W-1:0];
         end else begin
            adc_data = idle_sample;
         end
         next_cycle();
      end
   endtask

   task automatic follow_counter(input string name, input int n);
      repeat (3) next_cycle();  // flush the adc values still in the pipe
      repeat (n) begin
         next_cycle();
         // counter holds k during cycle k and reaches sample_o two cycles later
         check_sample(name, SAMPLE_W'(cycle_count - 2), sample);
      end
   endtask

   task automatic fire_trigger(input string name, input logic [SAMPLE_W-1:0] value,
                               input logic expect_pulse);
      adc_data = value;
      for (int i = 1; i <= 5; i++) begin
         next_cycle();
         adc_data = idle_sample;
         check_bit(name, (i == 3) ? expect_pulse : 1'b0, trigger_adc);
      end
   endtask

   task automatic count_gain_pulses(input string name, input logic [7:0] exp);
      logic [7:0] high_count;
      high_count = '0;
      repeat (2) next_cycle();  // let the new gain reach the carry
      repeat (256) begin
         next_cycle();
         high_count = high_count + {7'd0, amp_gain};
      end
      check_byte(name, exp, high_count);
   endtask

   task automatic measure_strobe(input string name, input int n, input logic [7:0] exp);
      logic [7:0] gap;
      gap = '0;
      while (!freq_measure && gap < 8'd80) begin
         next_cycle();
         gap = gap + 8'd1;
      end
      if (!freq_measure)
         stop_on_error($sformatf("%s freq_measure_o never pulsed", name));
      repeat (n) begin
         gap = '0;
         do begin
            next_cycle();
            gap = gap + 8'd1;
         end while (!freq_measure && gap < 8'd80);
         check_byte(name, exp, gap);  // cycles between strobes
      end
   endtask

   task automatic watch_leds(input string name, input led_sel_t mode, input logic [1:0] exp,
                             input int n);
      logic flash_exp;
      repeat (n) begin
         next_cycle();
         flash_exp = flash_at(cycle_count);
         case (mode)
            LED_STATE: begin
               check_bit(name, exp[0], led_armed);
               check_bit(name, exp[1], led_capture);
            end
            LED_FLASH: begin
               check_bit(name, flash_exp, flash_pattern);
               check_bit(name, flash_exp, led_armed);
               check_bit(name, flash_exp, led_capture);
            end
            LED_OFF: begin
               check_bit(name, 1'b0, led_armed);
               check_bit(name, 1'b0, led_capture);
            end
            default:
               stop_on_error($sformatf("%s uses an LED mode the test does not cover", name));
         endcase
      end
   endtask

   // rough cycle count of one step, for the watchdog
   function automatic int step_cycles(input logic [31:0] op, input logic [31:0] data);
      case (op[7:0])
         "W", "R": return 1;
         "N":      return int'(data);
         "A":      return int'(data) + 2;
         "C":      return int'(data) + 3;
         "T":      return 5;
         "G":      return 258;
         "F":      return (int'(data) + 1) * 32;
         "L":      return int'(data);
         default:  return 0;
      endcase
   endfunction

   task automatic load_patterns();
      int          fd;
      int          fields;
      string       line;
      string       name;
      logic [31:0] op;
      logic [31:0] addr;
      logic [31:0] cnt;
      logic [31:0] data;
      logic [31:0] exp;
      fd = $fopen("tb/scope_patterns.txt", "r");
      if (fd == 0)
         stop_on_error("could not open tb/scope_patterns.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#") begin
            fields = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, cnt, data, exp);
            if (fields != 6)
               stop_on_error($sformatf("pattern line cannot be parsed: %s", line));
            step_name.push_back(name);
            step_op.push_back(op);
            step_addr.push_back(addr);
            step_cnt.push_back(cnt);
            step_data.push_back(data);
            step_exp.push_back(exp);
         end
      end
      $fclose(fd);
   endtask

   task automatic execute_step(input int i);
      string       name;
      logic [31:0] addr;
      logic [31:0] cnt;
      logic [31:0] data;
      logic [31:0] exp;
      logic [31:0] op;
      name = step_name[i];
      op   = step_op[i];
      addr = step_addr[i];
      cnt  = step_cnt[i];
      data = step_data[i];
      exp  = step_exp[i];
      case (op[7:0])
         "W": bus_write(addr[7:0], cnt[BYTECNT_SIZE-1:0], data[7:0]);
         "R": bus_read_check(name, addr[7:0], cnt[BYTECNT_SIZE-1:0], exp[7:0]);
         "S": begin
            idle_sample = data[SAMPLE_W-1:0];
            adc_data    = idle_sample;
         end
         "N": repeat (data) next_cycle();
         "A": drive_adc_samples(name, int'(data));
         "C": follow_counter(name, int'(data));
         "T": fire_trigger(name, data[SAMPLE_W-1:0], exp[0]);
         "G": count_gain_pulses(name, exp[7:0]);
         "F": measure_strobe(name, int'(data), exp[7:0]);
         "L": watch_leds(name, led_sel_t'(addr[1:0]), exp[1:0], int'(data));
         default: stop_on_error($sformatf("step %s has an unknown operation", name));
      endcase
      if (dut0.u_level_trigger.u_scope_asserts.fail_count != 0)
         stop_on_error($sformatf("trigger assertion failed during step %s", name));
   endtask

   initial begin
      int total;
      reset    = 1'b1;
      reg_req  = '0;
      adc_data = '0;
      total    = 0;
      load_patterns();
      foreach (step_op[i])
         total += step_cycles(step_op[i], step_data[i]);
      limit_cycles = 4 * total + 2000;
      repeat (4) @(posedge clk_usb);
      #1;
      reset = 1'b0;
      foreach (step_op[i])
         execute_step(i);
      if (errors == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         stop_on_error("checks failed during the run");
      end
   end

   // watchdog
   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clk_usb);
      stop_on_error($sformatf("run timed out after %0d cycles", limit_cycles));
   end

endmodule

// File: tb/scope_patterns.txt
# columns: test op address bytecnt data expected, numbers in hex
# op: W write, R read, S idle sample, N wait, A adc, C counter, T trigger, G pwm, F strobe, L leds
rst_status   R 02 00 000 00
gain_wr      W 00 00 05a 00
gain_rd      R 00 00 000 5a
set_wr       W 01 00 00f 00
set_rd       R 01 00 000 07
lvl_lo_wr    W 03 00 034 00
lvl_hi_wr    W 03 01 0fa 00
lvl_lo_rd    R 03 00 000 34
lvl_hi_rd    R 03 01 000 0a
adc_src      W 01 00 001 00
adc_path     A 00 00 040 00
cnt_src      W 01 00 000 00
cnt_path     C 00 00 030 00
trig_idle    S 00 00 100 00
trig_src     W 01 00 001 00
trig_lvl_lo  W 03 00 000 00
trig_lvl_hi  W 03 01 009 00
trig_arm     W 01 00 019 00
trig_wait    N 00 00 004 00
trig_armed   R 02 00 000 01
trig_fire    T 00 00 a00 01
trig_status  R 02 00 000 02
trig_again   T 00 00 b00 00
trig_set_rd  R 01 00 000 11
rearm_idle   S 00 00 500 00
rearm_lvl_lo W 03 00 000 00
rearm_lvl_hi W 03 01 003 00
rearm        W 01 00 019 00
rearm_wait   N 00 00 004 00
rearm_fire   T 00 00 100 01
rearm_status R 02 00 000 02
pwm_gain_a   W 00 00 005 00
pwm_count_a  G 00 00 000 05
pwm_gain_b   W 00 00 080 00
pwm_count_b  G 00 00 000 80
pwm_gain_c   W 00 00 0ff 00
pwm_count_c  G 00 00 000 ff
freq_strobe  F 00 00 003 20
led_state    W 01 00 001 00
led_state_a  L 00 00 028 02
led_arm      W 01 00 009 00
led_state_b  L 00 00 028 01
led_flash    W 01 00 005 00
led_flash_a  L 02 00 140 00
led_off      W 01 00 007 00
led_off_a    L 03 00 028 00

// File: tb.f
common/scope_pkg.sv
verilog/reg_file.sv
verilog/panel_leds.sv
trigger/adc_front_end.sv
trigger/level_trigger.sv
verilog/scope_top.sv
tb/scope_asserts.sv
tb/scope_tb.sv

// File: Makefile
SIM = obj_dir/Vscope_tb

all: run

compile:
	verilator --binary --timing --assert --top-module scope_tb -f tb.f -o Vscope_tb

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
